//--- include/field_config.svh
// ====================================================================
// Field constants for the Fp2 arithmetic block, shared by the package,
// the RTL and the testbench. Include it wherever a constant is needed
// ====================================================================

`ifndef FIELD_CONFIG_SVH
`define FIELD_CONFIG_SVH

// Prime modulus p and the non-residue beta, with u^2 = beta
`define FP_MODULUS     65521
`define FP_NONRESIDUE  17
// Barrett constant floor(2^32 / p)
`define FP_BARRETT_MU  65551
// Width of the caller tag that rides along with each request
`define USER_TAG_BITS  4

`endif

//--- logic/field_pkg.sv
// ====================================================================
// Element and request types for the Fp2 arithmetic block. Modules use
// them through scoped names
// ====================================================================

`default_nettype none

`include "field_config.svh"

package field_pkg;
  typedef logic [15:0] fp_t;
  // c0 + c1*u
  typedef struct packed {
    fp_t c1;
    fp_t c0;
  } fp2_t;
  typedef logic [3:0] step_t;
  typedef struct packed {
    fp_t                       a;
    fp_t                       b;
    logic                      sub;
    step_t                     step;
    logic [`USER_TAG_BITS-1:0] user;
  } as_req_t;
  typedef struct packed {
    fp_t                       res;
    step_t                     step;
    logic [`USER_TAG_BITS-1:0] user;
  } as_rsp_t;
endpackage

`default_nettype wire

//--- logic/fp_add_sub.sv
// ====================================================================
// Modular adder/subtractor over Fp with one cycle of latency. Step and
// user fields pass through to the response unchanged
// ====================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp_add_sub (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_req_val,
  output logic               o_req_rdy,
  input  field_pkg::as_req_t i_req,
  output logic               o_rsp_val,
  input  logic               i_rsp_rdy,
  output field_pkg::as_rsp_t o_rsp
);
  localparam logic [16:0] P = 17'(`FP_MODULUS);

  logic [16:0] sum;
  logic [16:0] diff;
  logic [16:0] res;

  assign o_req_rdy = ~o_rsp_val | i_rsp_rdy;
  assign sum  = {1'b0, i_req.a} + {1'b0, i_req.b};
  assign diff = {1'b0, i_req.a} - {1'b0, i_req.b};

  // One correction by p brings either result back into range
  always_comb begin
    if (i_req.sub) begin
      res = diff[16] ? diff + P : diff;
    end else begin
      res = (sum >= P) ? sum - P : sum;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp_val <= 1'b0;
    end else if (o_req_rdy) begin
      o_rsp_val <= i_req_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_req_rdy && i_req_val) begin
      o_rsp.res  <= res[15:0];
      o_rsp.step <= i_req.step;
      o_rsp.user <= i_req.user;
    end
  end
endmodule

`default_nettype wire

//--- logic/fp_mod_mul.sv
// ====================================================================
// Three-stage modular multiplier over Fp using Barrett reduction.
// The pipeline stalls as a whole while its output is held
// ====================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp_mod_mul (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_val,
  output logic             o_rdy,
  input  field_pkg::fp_t   i_a,
  input  field_pkg::fp_t   i_b,
  input  field_pkg::step_t i_step,
  output logic             o_val,
  input  logic             i_rdy,
  output field_pkg::fp_t   o_res,
  output field_pkg::step_t o_step
);
  localparam logic [17:0] P  = 18'(`FP_MODULUS);
  localparam logic [16:0] MU = 17'(`FP_BARRETT_MU);

  logic             en;
  logic             v1;
  logic             v2;
  logic [31:0]      x1;
  logic [31:0]      x2;
  logic [16:0]      q2;
  field_pkg::step_t st1;
  field_pkg::step_t st2;
  logic [33:0]      q_full;
  logic [17:0]      r0;
  logic [17:0]      r1;
  logic [17:0]      r2;

  assign en    = ~o_val | i_rdy;
  assign o_rdy = en;

  // Quotient estimate from the top 17 bits, low by at most two
  assign q_full = x1[31:15] * MU;

  // Remainder is below 3p, so 18 bits hold it exactly
  assign r0 = x2[17:0] - 18'(q2 * P);
  assign r1 = (r0 >= P) ? r0 - P : r0;
  assign r2 = (r1 >= P) ? r1 - P : r1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1    <= 1'b0;
      v2    <= 1'b0;
      o_val <= 1'b0;
    end else if (en) begin
      v1    <= i_val;
      v2    <= v1;
      o_val <= v2;
    end
  end

  always_ff @(posedge i_clk) begin
    if (en) begin
      x1     <= i_a * i_b;
      st1    <= i_step;
      x2     <= x1;
      q2     <= q_full[33:17];
      st2    <= st1;
      o_res  <= r2[15:0];
      o_step <= st2;
    end
  end
endmodule

`default_nettype wire

//--- logic/unit_share.sv
// ====================================================================
// Round-robin sharing of one in-order unit among NUM_IN requesters.
// Responses are steered back by the index recorded at grant time
// ====================================================================

`timescale 1ns/100ps
`default_nettype none

module unit_share #(
  parameter int  NUM_IN = 2,
  parameter type REQ_T  = logic,
  parameter type RSP_T  = logic
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [NUM_IN-1:0] i_req_val,
  output logic [NUM_IN-1:0] o_req_rdy,
  input  REQ_T              i_req [NUM_IN],
  output logic              o_unit_val,
  input  logic              i_unit_rdy,
  output REQ_T              o_unit_req,
  input  logic              i_unit_val,
  output logic              o_unit_rdy,
  input  RSP_T              i_unit_rsp,
  output logic [NUM_IN-1:0] o_rsp_val,
  input  logic [NUM_IN-1:0] i_rsp_rdy,
  output RSP_T              o_rsp [NUM_IN]
);
  localparam int IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;
  // One op inside the unit plus one in its output register
  localparam int DEPTH = 2;
  localparam int PTR_W = $clog2(DEPTH);

  logic [IDX_W-1:0] prio;
  logic [IDX_W-1:0] gnt_idx;
  logic [IDX_W-1:0] head;
  logic             gnt_val;
  logic [IDX_W-1:0] idx_fifo [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  // First valid requester at or after the priority pointer
  always_comb begin
    int unsigned j;
    gnt_val = 1'b0;
    gnt_idx = '0;
    for (int k = NUM_IN - 1; k >= 0; k--) begin
      j = (int'(prio) + k) % NUM_IN;
      if (i_req_val[j]) begin
        gnt_val = 1'b1;
        gnt_idx = IDX_W'(j);
      end
    end
  end

  assign o_unit_val = gnt_val && (count != (PTR_W+1)'(DEPTH));
  assign o_unit_req = i_req[gnt_idx];
  assign push       = o_unit_val && i_unit_rdy;

  assign head       = idx_fifo[rd_ptr];
  assign o_unit_rdy = (count != '0) && i_rsp_rdy[head];
  assign pop        = i_unit_val && o_unit_rdy;

  always_comb begin
    for (int k = 0; k < NUM_IN; k++) begin
      o_req_rdy[k] = push && (gnt_idx == IDX_W'(k));
      o_rsp_val[k] = i_unit_val && (count != '0) && (head == IDX_W'(k));
      o_rsp[k]     = i_unit_rsp;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio   <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        prio   <= (gnt_idx == IDX_W'(NUM_IN - 1)) ? '0 : gnt_idx + 1'b1;
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      idx_fifo[wr_ptr] <= gnt_idx;
    end
  end
endmodule

`default_nettype wire

//--- logic/fp2_elementwise.sv
// ====================================================================
// Fp2 add/sub channel. Each element goes out as two Fp operations,
// c0 then c1, and is rebuilt when the c1 half comes back
// ====================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp2_elementwise (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_ew_val,
  output logic                      o_ew_rdy,
  input  field_pkg::fp2_t           i_ew_a,
  input  field_pkg::fp2_t           i_ew_b,
  input  logic                      i_ew_sub,
  input  logic [`USER_TAG_BITS-1:0] i_ew_tag,
  output logic                      o_req_val,
  input  logic                      i_req_rdy,
  output field_pkg::as_req_t        o_req,
  input  logic                      i_rsp_val,
  output logic                      o_rsp_rdy,
  input  field_pkg::as_rsp_t        i_rsp,
  output logic                      o_ew_res_val,
  input  logic                      i_ew_res_rdy,
  output field_pkg::fp2_t           o_ew_res,
  output logic [`USER_TAG_BITS-1:0] o_ew_res_tag
);
  logic           half;
  logic           req_free;
  field_pkg::fp_t lo_res;

  assign req_free  = ~o_req_val | i_req_rdy;
  // Request is consumed with its second half
  assign o_ew_rdy  = half & req_free;
  assign o_rsp_rdy = ~o_ew_res_val | i_ew_res_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      half         <= 1'b0;
      o_req_val    <= 1'b0;
      o_ew_res_val <= 1'b0;
    end else begin
      if (req_free) begin
        o_req_val <= i_ew_val;
        if (i_ew_val) begin
          half <= ~half;
        end
      end
      if (o_ew_res_val && i_ew_res_rdy) begin
        o_ew_res_val <= 1'b0;
      end
      if (i_rsp_val && o_rsp_rdy && i_rsp.step[0]) begin
        o_ew_res_val <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_free) begin
      o_req.a    <= half ? i_ew_a.c1 : i_ew_a.c0;
      o_req.b    <= half ? i_ew_b.c1 : i_ew_b.c0;
      o_req.sub  <= i_ew_sub;
      o_req.step <= field_pkg::step_t'(half);
      o_req.user <= i_ew_tag;
    end
    // Half 0 waits in lo_res until its partner arrives
    if (i_rsp_val && o_rsp_rdy) begin
      if (i_rsp.step[0]) begin
        o_ew_res.c1  <= i_rsp.res;
        o_ew_res.c0  <= lo_res;
        o_ew_res_tag <= i_rsp.user;
      end else begin
        lo_res <= i_rsp.res;
      end
    end
  end
endmodule

`default_nettype wire

//--- logic/fp2_mul_sched.sv
// ====================================================================
// Karatsuba Fp2 multiply. Nine steps are issued to the shared add/sub
// unit and the multiplier as their inputs become available
// ====================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp2_mul_sched (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_mul_val,
  output logic                      o_mul_rdy,
  input  field_pkg::fp2_t           i_mul_a,
  input  field_pkg::fp2_t           i_mul_b,
  input  logic [`USER_TAG_BITS-1:0] i_mul_tag,
  output logic                      o_req_val,
  input  logic                      i_req_rdy,
  output field_pkg::as_req_t        o_req,
  input  logic                      i_rsp_val,
  output logic                      o_rsp_rdy,
  input  field_pkg::as_rsp_t        i_rsp,
  output logic                      o_mm_val,
  input  logic                      i_mm_rdy,
  output field_pkg::fp_t            o_mm_a,
  output field_pkg::fp_t            o_mm_b,
  output field_pkg::step_t          o_mm_step,
  input  logic                      i_mm_val,
  output logic                      o_mm_rdy,
  input  field_pkg::fp_t            i_mm_res,
  input  field_pkg::step_t          i_mm_step,
  output logic                      o_mul_res_val,
  input  logic                      i_mul_res_rdy,
  output field_pkg::fp2_t           o_mul_res,
  output logic [`USER_TAG_BITS-1:0] o_mul_res_tag
);
  localparam field_pkg::fp_t BETA = 16'(`FP_NONRESIDUE);
  // Steps 0,1,4,5 are products, the rest go to the add/sub unit
  localparam logic [8:0] MM_STEPS = 9'b000110011;
  localparam logic [8:0] AS_STEPS = 9'b111001100;

  logic [8:0]       issued;
  logic [8:0]       done;
  logic [8:0]       dep_ok;
  logic [8:0]       mm_cand;
  logic [8:0]       as_cand;
  field_pkg::fp_t   val_q [9];
  field_pkg::step_t mm_pick;
  field_pkg::step_t as_pick;
  field_pkg::fp_t   mm_a;
  field_pkg::fp_t   mm_b;
  field_pkg::fp_t   as_a;
  field_pkg::fp_t   as_b;
  logic             mm_free;
  logic             as_free;
  logic             res_take;

  // c1 = t - bb, t = m - aa, c0 = aa + nb, nb = beta*bb, m = sa*sb
  assign dep_ok = {done[7] & done[1], done[4] & done[0], done[0] & done[5], done[1],
                   done[2] & done[3], {4{i_mul_val}}};
  assign mm_cand = dep_ok & ~issued & MM_STEPS;
  assign as_cand = dep_ok & ~issued & AS_STEPS;
  assign mm_free = ~o_mm_val | i_mm_rdy;
  assign as_free = ~o_req_val | i_req_rdy;

  assign o_mm_rdy      = 1'b1;
  assign o_rsp_rdy     = 1'b1;
  assign o_mul_res_val = &done;
  assign o_mul_res     = '{c1: val_q[8], c0: val_q[6]};
  assign o_mul_res_tag = i_mul_tag;
  assign res_take      = o_mul_res_val & i_mul_res_rdy;
  assign o_mul_rdy     = res_take;

  // Lowest ready step per unit
  always_comb begin
    mm_pick = '0;
    as_pick = '0;
    for (int k = 8; k >= 0; k--) begin
      if (mm_cand[k]) mm_pick = field_pkg::step_t'(k);
      if (as_cand[k]) as_pick = field_pkg::step_t'(k);
    end
  end

  always_comb begin
    mm_a = i_mul_a.c0;
    mm_b = i_mul_b.c0;
    as_a = i_mul_a.c0;
    as_b = i_mul_a.c1;
    case (mm_pick)
      4'd1: begin mm_a = i_mul_a.c1; mm_b = i_mul_b.c1; end
      4'd4: begin mm_a = val_q[2]; mm_b = val_q[3]; end
      4'd5: begin mm_a = BETA; mm_b = val_q[1]; end
      default: ;
    endcase
    case (as_pick)
      4'd3: begin as_a = i_mul_b.c0; as_b = i_mul_b.c1; end
      4'd6: begin as_a = val_q[0]; as_b = val_q[5]; end
      4'd7: begin as_a = val_q[4]; as_b = val_q[0]; end
      4'd8: begin as_a = val_q[7]; as_b = val_q[1]; end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      issued    <= '0;
      done      <= '0;
      o_mm_val  <= 1'b0;
      o_req_val <= 1'b0;
    end else begin
      if (mm_free) begin
        o_mm_val <= |mm_cand;
        if (|mm_cand) issued[mm_pick] <= 1'b1;
      end
      if (as_free) begin
        o_req_val <= |as_cand;
        if (|as_cand) issued[as_pick] <= 1'b1;
      end
      if (i_mm_val) done[i_mm_step] <= 1'b1;
      if (i_rsp_val) done[i_rsp.step] <= 1'b1;
      if (res_take) begin
        issued <= '0;
        done   <= '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (mm_free) begin
      o_mm_a    <= mm_a;
      o_mm_b    <= mm_b;
      o_mm_step <= mm_pick;
    end
    if (as_free) begin
      o_req <= '{a: as_a, b: as_b, sub: (as_pick >= 4'd7), step: as_pick, user: i_mul_tag};
    end
    if (i_mm_val) val_q[i_mm_step] <= i_mm_res;
    if (i_rsp_val) val_q[i_rsp.step] <= i_rsp.res;
  end
endmodule

`default_nettype wire

//--- logic/fp2_arith_top.sv
// ====================================================================
// Fp2 arithmetic top level. The element-wise and multiply channels
// share one add/sub unit, and the multiply scheduler owns a multiplier
// ====================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp2_arith_top (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_ew_val,
  output logic                      o_ew_rdy,
  input  field_pkg::fp2_t           i_ew_a,
  input  field_pkg::fp2_t           i_ew_b,
  input  logic                      i_ew_sub,
  input  logic [`USER_TAG_BITS-1:0] i_ew_tag,
  output logic                      o_ew_res_val,
  input  logic                      i_ew_res_rdy,
  output field_pkg::fp2_t           o_ew_res,
  output logic [`USER_TAG_BITS-1:0] o_ew_res_tag,
  input  logic                      i_mul_val,
  output logic                      o_mul_rdy,
  input  field_pkg::fp2_t           i_mul_a,
  input  field_pkg::fp2_t           i_mul_b,
  input  logic [`USER_TAG_BITS-1:0] i_mul_tag,
  output logic                      o_mul_res_val,
  input  logic                      i_mul_res_rdy,
  output field_pkg::fp2_t           o_mul_res,
  output logic [`USER_TAG_BITS-1:0] o_mul_res_tag
);
  // Requester 0 is the element-wise channel, 1 the multiply scheduler
  logic [1:0]         sh_req_val;
  logic [1:0]         sh_req_rdy;
  field_pkg::as_req_t sh_req [2];
  logic [1:0]         sh_rsp_val;
  logic [1:0]         sh_rsp_rdy;
  field_pkg::as_rsp_t sh_rsp [2];
  logic               as_val;
  logic               as_rdy;
  field_pkg::as_req_t as_req;
  logic               as_rsp_val;
  logic               as_rsp_rdy;
  field_pkg::as_rsp_t as_rsp;
  logic               mm_val;
  logic               mm_rdy;
  field_pkg::fp_t     mm_a;
  field_pkg::fp_t     mm_b;
  field_pkg::step_t   mm_step;
  logic               mm_res_val;
  logic               mm_res_rdy;
  field_pkg::fp_t     mm_res;
  field_pkg::step_t   mm_res_step;

  fp2_elementwise fp2_elementwise_inst (
    .i_clk, .i_rst, .i_ew_val, .o_ew_rdy, .i_ew_a, .i_ew_b, .i_ew_sub, .i_ew_tag,
    .o_req_val(sh_req_val[0]), .i_req_rdy(sh_req_rdy[0]), .o_req(sh_req[0]),
    .i_rsp_val(sh_rsp_val[0]), .o_rsp_rdy(sh_rsp_rdy[0]), .i_rsp(sh_rsp[0]),
    .o_ew_res_val, .i_ew_res_rdy, .o_ew_res, .o_ew_res_tag
  );

  fp2_mul_sched fp2_mul_sched_inst (
    .i_clk, .i_rst, .i_mul_val, .o_mul_rdy, .i_mul_a, .i_mul_b, .i_mul_tag,
    .o_req_val(sh_req_val[1]), .i_req_rdy(sh_req_rdy[1]), .o_req(sh_req[1]),
    .i_rsp_val(sh_rsp_val[1]), .o_rsp_rdy(sh_rsp_rdy[1]), .i_rsp(sh_rsp[1]),
    .o_mm_val(mm_val), .i_mm_rdy(mm_rdy), .o_mm_a(mm_a), .o_mm_b(mm_b),
    .o_mm_step(mm_step), .i_mm_val(mm_res_val), .o_mm_rdy(mm_res_rdy),
    .i_mm_res(mm_res), .i_mm_step(mm_res_step),
    .o_mul_res_val, .i_mul_res_rdy, .o_mul_res, .o_mul_res_tag
  );

  unit_share #(
    .NUM_IN(2),
    .REQ_T (field_pkg::as_req_t),
    .RSP_T (field_pkg::as_rsp_t)
  ) unit_share_inst (
    .i_clk, .i_rst,
    .i_req_val(sh_req_val), .o_req_rdy(sh_req_rdy), .i_req(sh_req),
    .o_unit_val(as_val), .i_unit_rdy(as_rdy), .o_unit_req(as_req),
    .i_unit_val(as_rsp_val), .o_unit_rdy(as_rsp_rdy), .i_unit_rsp(as_rsp),
    .o_rsp_val(sh_rsp_val), .i_rsp_rdy(sh_rsp_rdy), .o_rsp(sh_rsp)
  );

  fp_add_sub fp_add_sub_inst (
    .i_clk, .i_rst,
    .i_req_val(as_val), .o_req_rdy(as_rdy), .i_req(as_req),
    .o_rsp_val(as_rsp_val), .i_rsp_rdy(as_rsp_rdy), .o_rsp(as_rsp)
  );

  fp_mod_mul fp_mod_mul_inst (
    .i_clk, .i_rst,
    .i_val(mm_val), .o_rdy(mm_rdy), .i_a(mm_a), .i_b(mm_b), .i_step(mm_step),
    .o_val(mm_res_val), .i_rdy(mm_res_rdy), .o_res(mm_res), .o_step(mm_res_step)
  );
endmodule

`default_nettype wire

//--- sim/fp2_arith_props.sv
// ======================================================================
// Concurrent checks on the result channels of the Fp2 top level.
// Bound into fp2_arith_top below
// ======================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp2_arith_props (
  input wire logic                      i_clk,
  input wire logic                      i_rst,
  input wire logic                      o_ew_res_val,
  input wire logic                      i_ew_res_rdy,
  input wire field_pkg::fp2_t           o_ew_res,
  input wire logic [`USER_TAG_BITS-1:0] o_ew_res_tag,
  input wire logic                      o_mul_res_val,
  input wire logic                      i_mul_res_rdy,
  input wire field_pkg::fp2_t           o_mul_res,
  input wire logic [`USER_TAG_BITS-1:0] o_mul_res_tag
);
  int fail_count = 0;

  // A result that is not taken stays put
  ew_res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ew_res_val && !i_ew_res_rdy |=> o_ew_res_val && $stable({o_ew_res, o_ew_res_tag}))
    else begin
      $error("element-wise result dropped or changed before it was taken");
      fail_count++;
    end

  mul_res_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mul_res_val && !i_mul_res_rdy |=> o_mul_res_val && $stable({o_mul_res, o_mul_res_tag}))
    else begin
      $error("multiply result dropped or changed before it was taken");
      fail_count++;
    end

  res_idle_after_rst: assert property (@(posedge i_clk)
    i_rst |=> !o_ew_res_val && !o_mul_res_val)
    else begin
      $error("result valid high right after reset");
      fail_count++;
    end

  // Coefficients are always fully reduced
  ew_res_range: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ew_res_val |-> o_ew_res.c0 < 16'(`FP_MODULUS) && o_ew_res.c1 < 16'(`FP_MODULUS))
    else begin
      $error("element-wise result coefficient not below the modulus");
      fail_count++;
    end

  mul_res_range: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mul_res_val |-> o_mul_res.c0 < 16'(`FP_MODULUS) && o_mul_res.c1 < 16'(`FP_MODULUS))
    else begin
      $error("multiply result coefficient not below the modulus");
      fail_count++;
    end
endmodule

bind fp2_arith_top fp2_arith_props fp2_arith_props_inst (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .o_ew_res_val(o_ew_res_val),
  .i_ew_res_rdy(i_ew_res_rdy),
  .o_ew_res(o_ew_res),
  .o_ew_res_tag(o_ew_res_tag),
  .o_mul_res_val(o_mul_res_val),
  .i_mul_res_rdy(i_mul_res_rdy),
  .o_mul_res(o_mul_res),
  .o_mul_res_tag(o_mul_res_tag)
);

`default_nettype wire

//--- sim/fp2_arith_tb.sv
// ======================================================================
// Testbench for the Fp2 arithmetic top level. Drives both channels
// with LFSR operands and checks every result against a software model
// ======================================================================

`timescale 1ns/100ps
`default_nettype none

`include "field_config.svh"

module fp2_arith_tb;
  localparam longint P          = `FP_MODULUS;
  localparam longint BETA       = `FP_NONRESIDUE;
  localparam int     NUM_REQ    = 64;
  localparam int     MAX_CYCLES = 20000;
  localparam int     EXP_W      = `USER_TAG_BITS + 32;
  localparam int     OP_ADD     = 0;
  localparam int     OP_SUB     = 1;
  localparam int     OP_MUL     = 2;

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_ew_val;
  logic                      o_ew_rdy;
  field_pkg::fp2_t           i_ew_a;
  field_pkg::fp2_t           i_ew_b;
  logic                      i_ew_sub;
  logic [`USER_TAG_BITS-1:0] i_ew_tag;
  logic                      o_ew_res_val;
  logic                      i_ew_res_rdy;
  field_pkg::fp2_t           o_ew_res;
  logic [`USER_TAG_BITS-1:0] o_ew_res_tag;
  logic                      i_mul_val;
  logic                      o_mul_rdy;
  field_pkg::fp2_t           i_mul_a;
  field_pkg::fp2_t           i_mul_b;
  logic [`USER_TAG_BITS-1:0] i_mul_tag;
  logic                      o_mul_res_val;
  logic                      i_mul_res_rdy;
  field_pkg::fp2_t           o_mul_res;
  logic [`USER_TAG_BITS-1:0] o_mul_res_tag;

  logic [31:0]               lfsr_state;
  logic [`USER_TAG_BITS-1:0] ew_tag;
  logic [`USER_TAG_BITS-1:0] mul_tag;
  logic [EXP_W-1:0]          ew_exp_q [$];
  logic [EXP_W-1:0]          mul_exp_q [$];
  field_pkg::fp2_t           mix_ew_a [NUM_REQ];
  field_pkg::fp2_t           mix_ew_b [NUM_REQ];
  logic                      mix_ew_sub [NUM_REQ];
  field_pkg::fp2_t           mix_mul_a [NUM_REQ];
  field_pkg::fp2_t           mix_mul_b [NUM_REQ];
  logic                      ew_sent;
  logic                      mul_sent;
  int                        checks;
  int                        errors;
  int                        checks_mark;
  int                        errors_mark;
  int                        cycle_count;

  fp2_arith_top fp2_arith_top_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic field_pkg::fp_t rand_fp();
    longint v;
    v = longint'(draw_bits(16));
    while (v >= P) begin
      v = v - P;
    end
    return 16'(v);
  endfunction

  function automatic field_pkg::fp2_t rand_fp2();
    field_pkg::fp2_t r;
    r.c0 = rand_fp();
    r.c1 = rand_fp();
    return r;
  endfunction

  // Picks 0, 1 or p-1
  function automatic field_pkg::fp_t edge_value();
    logic [31:0] sel;
    sel = draw_bits(2);
    case (sel[1:0])
      2'd0: return 16'd0;
      2'd1: return 16'd1;
      default: return 16'(P - 1);
    endcase
  endfunction

  function automatic field_pkg::fp2_t edge_fp2();
    field_pkg::fp2_t r;
    r.c0 = edge_value();
    r.c1 = edge_value();
    return r;
  endfunction

  // Expected Fp2 result with u^2 = beta
  function automatic field_pkg::fp2_t fp2_model(input int op, input field_pkg::fp2_t a,
                                                 input field_pkg::fp2_t b);
    longint          a0;
    longint          a1;
    longint          b0;
    longint          b1;
    longint          c0;
    longint          c1;
    field_pkg::fp2_t r;
    a0 = longint'(a.c0);
    a1 = longint'(a.c1);
    b0 = longint'(b.c0);
    b1 = longint'(b.c1);
    if (op == OP_ADD) begin
      c0 = (a0 + b0) % P;
      c1 = (a1 + b1) % P;
    end else if (op == OP_SUB) begin
      c0 = (a0 - b0 + P) % P;
      c1 = (a1 - b1 + P) % P;
    end else begin
      c0 = (a0 * b0 + BETA * ((a1 * b1) % P)) % P;
      c1 = (a0 * b1 + a1 * b0) % P;
    end
    r.c0 = 16'(c0);
    r.c1 = 16'(c1);
    return r;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Expected values enter the queues at request accept and results leave them
  always @(posedge i_clk) begin
    logic [EXP_W-1:0] expected;
    if (!i_rst) begin
      if (i_ew_val && o_ew_rdy) begin
        ew_exp_q.push_back({i_ew_tag, fp2_model(i_ew_sub ? OP_SUB : OP_ADD, i_ew_a, i_ew_b)});
      end
      if (i_mul_val && o_mul_rdy) begin
        mul_exp_q.push_back({i_mul_tag, fp2_model(OP_MUL, i_mul_a, i_mul_b)});
      end
      if (o_ew_res_val && i_ew_res_rdy) begin
        if (ew_exp_q.size() == 0) begin
          errors++;
          $display("Element-wise result at %0d ns arrived with no request outstanding", $time);
        end else begin
          expected = ew_exp_q.pop_front();
          compare_value("element-wise result", o_ew_res, expected[31:0]);
          compare_value("element-wise tag", 32'(o_ew_res_tag), 32'(expected[EXP_W-1:32]));
        end
      end
      if (o_mul_res_val && i_mul_res_rdy) begin
        if (mul_exp_q.size() == 0) begin
          errors++;
          $display("Multiply result at %0d ns arrived with no request outstanding", $time);
        end else begin
          expected = mul_exp_q.pop_front();
          compare_value("multiply result", o_mul_res, expected[31:0]);
          compare_value("multiply tag", 32'(o_mul_res_tag), 32'(expected[EXP_W-1:32]));
        end
      end
    end
  end

  // Called on a falling edge and returns on the falling edge after accept
  task automatic send_ew(input logic sub, input field_pkg::fp2_t a, input field_pkg::fp2_t b);
    i_ew_val = 1'b1;
    i_ew_sub = sub;
    i_ew_a   = a;
    i_ew_b   = b;
    i_ew_tag = ew_tag;
    do @(posedge i_clk); while (!o_ew_rdy);
    ew_tag = ew_tag + 1'b1;
    @(negedge i_clk);
    i_ew_val = 1'b0;
  endtask

  // Accept of a multiply coincides with taking its result
  task automatic send_mul(input field_pkg::fp2_t a, input field_pkg::fp2_t b);
    i_mul_val = 1'b1;
    i_mul_a   = a;
    i_mul_b   = b;
    i_mul_tag = mul_tag;
    do @(posedge i_clk); while (!o_mul_rdy);
    mul_tag = mul_tag + 1'b1;
    @(negedge i_clk);
    i_mul_val = 1'b0;
  endtask

  task automatic finish_test(input string name);
    while (ew_exp_q.size() != 0 || mul_exp_q.size() != 0) begin
      @(negedge i_clk);
    end
    $display("Test %s done: %0d checks, %0d errors", name, checks - checks_mark,
             errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  task automatic run_ew_test(input logic sub);
    field_pkg::fp2_t a;
    field_pkg::fp2_t b;
    field_pkg::fp_t  t;
    for (int i = 0; i < NUM_REQ; i++) begin
      a = rand_fp2();
      b = rand_fp2();
      // Every other subtraction has a below b in both coefficients
      if (sub && i[0]) begin
        if (a.c0 > b.c0) begin
          t    = a.c0;
          a.c0 = b.c0;
          b.c0 = t;
        end
        if (a.c1 > b.c1) begin
          t    = a.c1;
          a.c1 = b.c1;
          b.c1 = t;
        end
      end
      send_ew(sub, a, b);
    end
  endtask

  task automatic run_mul_test();
    for (int i = 0; i < NUM_REQ; i++) begin
      send_mul(rand_fp2(), rand_fp2());
    end
  endtask

  task automatic run_edge_test();
    for (int i = 0; i < NUM_REQ; i++) begin
      if (i % 3 == OP_MUL) begin
        send_mul(edge_fp2(), edge_fp2());
      end else begin
        send_ew(i % 3 == OP_SUB, edge_fp2(), edge_fp2());
      end
    end
  endtask

  task automatic toggle_readies();
    logic [31:0] r;
    while (!(ew_sent && mul_sent)) begin
      r = draw_bits(2);
      i_ew_res_rdy  = r[0];
      i_mul_res_rdy = r[1];
      @(negedge i_clk);
    end
    i_ew_res_rdy  = 1'b1;
    i_mul_res_rdy = 1'b1;
  endtask

  task automatic run_mixed_test();
    logic [31:0] r;
    for (int i = 0; i < NUM_REQ; i++) begin
      mix_ew_a[i]  = rand_fp2();
      mix_ew_b[i]  = rand_fp2();
      r = draw_bits(1);
      mix_ew_sub[i] = r[0];
      mix_mul_a[i] = rand_fp2();
      mix_mul_b[i] = rand_fp2();
    end
    ew_sent  = 1'b0;
    mul_sent = 1'b0;
    fork
      begin
        for (int i = 0; i < NUM_REQ; i++) begin
          send_ew(mix_ew_sub[i], mix_ew_a[i], mix_ew_b[i]);
        end
        ew_sent = 1'b1;
      end
      begin
        for (int i = 0; i < NUM_REQ; i++) begin
          send_mul(mix_mul_a[i], mix_mul_b[i]);
        end
        mul_sent = 1'b1;
      end
      toggle_readies();
    join
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    i_rst         = 1'b1;
    i_ew_val      = 1'b0;
    i_ew_a        = '0;
    i_ew_b        = '0;
    i_ew_sub      = 1'b0;
    i_ew_tag      = '0;
    i_ew_res_rdy  = 1'b1;
    i_mul_val     = 1'b0;
    i_mul_a       = '0;
    i_mul_b       = '0;
    i_mul_tag     = '0;
    i_mul_res_rdy = 1'b1;
    lfsr_state    = 32'hd10;
    ew_tag        = '0;
    mul_tag       = '0;
    ew_sent       = 1'b0;
    mul_sent      = 1'b0;
    checks        = 0;
    errors        = 0;
    checks_mark   = 0;
    errors_mark   = 0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    run_ew_test(1'b0);
    finish_test("1 random add");
    run_ew_test(1'b1);
    finish_test("2 random sub");
    run_mul_test();
    finish_test("3 random mul");
    run_edge_test();
    finish_test("4 edge operands");
    run_mixed_test();
    finish_test("5 mixed traffic");

    errors = errors + fp2_arith_top_inst.fp2_arith_props_inst.fail_count;
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end
endmodule

`default_nettype wire

//--- all.f
+incdir+include
logic/field_pkg.sv
logic/fp_add_sub.sv
logic/fp_mod_mul.sv
logic/unit_share.sv
logic/fp2_elementwise.sv
logic/fp2_mul_sched.sv
logic/fp2_arith_top.sv
sim/fp2_arith_props.sv
sim/fp2_arith_tb.sv

//--- Makefile
# Verilator flow for the Fp2 arithmetic block

TOP = fp2_arith_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
